// ==== tcb_pkg.sv ====
//////////////////////////////
// tcb bus types
// request and response layout, opcode
// and the bus statistics record
//////////////////////////////

package tcb_pkg;

  // bus widths
  localparam int unsigned ADR_W = 16;
  localparam int unsigned DAT_W = 32;
  localparam int unsigned BEN_W = DAT_W / 8;

  // transfer opcode, one bit on the bus
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_t;

  // request, 55 bits
  typedef struct packed {
    bus_op_t            op;
    logic [ADR_W-1:0]   adr;
    logic [BEN_W-1:0]   ben;
    logic [DAT_W-1:0]   wdt;
    // arbitration lock
    logic               lck;
    // repeat access
    logic               rpt;
  } bus_req_t;

  // response, 33 bits
  typedef struct packed {
    logic [DAT_W-1:0]   rdt;
    logic               err;
  } bus_rsp_t;

  // running totals since reset
  typedef struct packed {
    logic [31:0] xfer_cnt;
    logic [31:0] wr_cnt;
    // idle and backpressure cycles, unsaturated
    logic [31:0] idle_sum;
    logic [31:0] bpr_sum;
  } bus_stats_t;

endpackage

// ==== trace_pkg.sv ====
//////////////////////////////
// trace types
// timing snapshot, trace record
// and the trace statistics record
//////////////////////////////

package trace_pkg;

  // timing field width, saturating
  localparam int unsigned CNT_W = 8;

  // cycles before a transfer
  typedef struct packed {
    // vld low
    logic [CNT_W-1:0] idl;
    // vld high, rdy low
    logic [CNT_W-1:0] bpr;
  } tmg_t;

  // one completed transaction
  // request and response as seen on the bus,
  // timing measured before the transfer
  typedef struct packed {
    tcb_pkg::bus_req_t req;
    tcb_pkg::bus_rsp_t rsp;
    tmg_t              tmg;
    // read with all byte enables low
    logic              no_ben;
  } trace_rec_t;

  // monitor side totals
  typedef struct packed {
    // error responses, dropped or not
    logic [31:0] err_cnt;
    // records lost to a full FIFO
    logic [31:0] drop_cnt;
  } trace_stats_t;

endpackage

// ==== tcb_req_tracker.sv ====
//////////////////////////////
// tcb request tracker
// pairs each transfer with its
// response DLY cycles later
//////////////////////////////

`timescale 1ns/1ps

module tcb_req_tracker #(
  parameter int DLY = 2
) (
  input  logic              tcb,
  input  logic              rst_n,
  input  logic              bus_vld,
  input  logic              bus_rdy,
  input  tcb_pkg::bus_req_t bus_req,
  input  tcb_pkg::bus_rsp_t bus_rsp,
  output logic              cmp_vld,
  output tcb_pkg::bus_req_t cmp_req,
  output tcb_pkg::bus_rsp_t cmp_rsp
);

  // ring pointer width, at least one bit
  localparam int PTR_W = (DLY > 1) ? $clog2(DLY) : 1;

  logic              trn;
  // transfer flags, bit i set i+1 cycles after a transfer
  logic [DLY-1:0]    due_q;
  // in-flight requests
  tcb_pkg::bus_req_t ring [DLY];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  // transfer on vld and rdy
  assign trn = bus_vld & bus_rdy;

  //////////////////////////////
  // response due line
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      due_q <= '0;
    end else begin
      due_q[0] <= trn;
      for (int i = 1; i < DLY; i++) begin
        due_q[i] <= due_q[i-1];
      end
    end
  end

  //////////////////////////////
  // request ring
  //////////////////////////////

  // pointers wrap at DLY
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (trn) begin
        if (wr_ptr == PTR_W'(DLY - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + 1'b1;
      end
      // oldest entry retires with its response
      if (cmp_vld) begin
        if (rd_ptr == PTR_W'(DLY - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // payload only
  always_ff @(posedge tcb) begin
    if (trn) ring[wr_ptr] <= bus_req;
  end

  // completion, same cycle as the response on the bus
  assign cmp_vld = due_q[DLY-1];
  assign cmp_req = ring[rd_ptr];
  assign cmp_rsp = bus_rsp;

endmodule

// ==== tcb_tmg_counter.sv ====
//////////////////////////////
// tcb timing counter
// idle and backpressure per transfer,
// bus statistics
//////////////////////////////

`timescale 1ns/1ps

module tcb_tmg_counter (
  input  logic                tcb,
  input  logic                rst_n,
  input  logic                bus_vld,
  input  logic                bus_rdy,
  input  tcb_pkg::bus_req_t   bus_req,
  output logic                snap_vld,
  output trace_pkg::tmg_t     snap_tmg,
  output tcb_pkg::bus_stats_t bus_stats
);

  logic                        trn;
  // saturating counts since the last transfer
  logic [trace_pkg::CNT_W-1:0] idl_cnt;
  logic [trace_pkg::CNT_W-1:0] bpr_cnt;

  assign trn = bus_vld & bus_rdy;

  //////////////////////////////
  // per-transfer timing
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      idl_cnt <= '0;
      bpr_cnt <= '0;
    end else if (trn) begin
      // restart on every transfer
      idl_cnt <= '0;
      bpr_cnt <= '0;
    end else if (!bus_vld) begin
      if (idl_cnt != '1) idl_cnt <= idl_cnt + 1'b1;
    end else begin
      // vld without rdy
      if (bpr_cnt != '1) bpr_cnt <= bpr_cnt + 1'b1;
    end
  end

  // snapshot in the transfer cycle, counts before it
  assign snap_vld     = trn;
  assign snap_tmg.idl = idl_cnt;
  assign snap_tmg.bpr = bpr_cnt;

  //////////////////////////////
  // bus statistics
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      bus_stats <= '0;
    end else begin
      if (trn) bus_stats.xfer_cnt <= bus_stats.xfer_cnt + 32'd1;
      if (trn && bus_req.op == tcb_pkg::OP_WRITE) bus_stats.wr_cnt <= bus_stats.wr_cnt + 32'd1;
      // sums do not saturate
      if (!bus_vld) bus_stats.idle_sum <= bus_stats.idle_sum + 32'd1;
      if (bus_vld && !bus_rdy) bus_stats.bpr_sum <= bus_stats.bpr_sum + 32'd1;
    end
  end

endmodule

// ==== tcb_trace_merge.sv ====
//////////////////////////////
// tcb trace merger
// pairs completions with timing in order,
// flags reads without byte enables,
// buffers records in a FIFO
//////////////////////////////

`timescale 1ns/1ps

module tcb_trace_merge #(
  parameter int DLY         = 2,
  parameter int TRACE_DEPTH = 8
) (
  input  logic                    tcb,
  input  logic                    rst_n,
  input  logic                    cmp_vld,
  input  tcb_pkg::bus_req_t       cmp_req,
  input  tcb_pkg::bus_rsp_t       cmp_rsp,
  input  logic                    snap_vld,
  input  trace_pkg::tmg_t         snap_tmg,
  input  logic                    trace_rdy,
  output logic                    trace_vld,
  output trace_pkg::trace_rec_t   trace_rec,
  output trace_pkg::trace_stats_t trace_stats
);

  // snapshot queue
  localparam int SQ_D = DLY + 1;
  localparam int SQ_W = $clog2(SQ_D);
  // trace FIFO address width
  localparam int FF_W = $clog2(TRACE_DEPTH);

  trace_pkg::tmg_t       snap_q [SQ_D];
  logic [SQ_W-1:0]       sq_wr;
  logic [SQ_W-1:0]       sq_rd;
  trace_pkg::trace_rec_t rec_in;
  trace_pkg::trace_rec_t fifo [TRACE_DEPTH];
  // one extra bit tells full from empty
  logic [FF_W:0]         ff_wr;
  logic [FF_W:0]         ff_rd;
  logic                  ff_full;
  logic                  ff_empty;
  logic                  push;
  logic                  pop;

  //////////////////////////////
  // timing snapshot queue
  //////////////////////////////

  // pushed in the transfer cycle, popped with the completion
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      sq_wr <= '0;
      sq_rd <= '0;
    end else begin
      if (snap_vld) begin
        if (sq_wr == SQ_W'(SQ_D - 1)) sq_wr <= '0;
        else sq_wr <= sq_wr + 1'b1;
      end
      if (cmp_vld) begin
        if (sq_rd == SQ_W'(SQ_D - 1)) sq_rd <= '0;
        else sq_rd <= sq_rd + 1'b1;
      end
    end
  end

  always_ff @(posedge tcb) begin
    if (snap_vld) snap_q[sq_wr] <= snap_tmg;
  end

  // record assembly
  always_comb begin
    rec_in.req    = cmp_req;
    rec_in.rsp    = cmp_rsp;
    rec_in.tmg    = snap_q[sq_rd];
    // protocol flag, reads only
    rec_in.no_ben = (cmp_req.op == tcb_pkg::OP_READ) && (cmp_req.ben == '0);
  end

  //////////////////////////////
  // trace FIFO
  //////////////////////////////

  assign ff_empty = (ff_wr == ff_rd);
  assign ff_full  = (ff_wr[FF_W] != ff_rd[FF_W]) && (ff_wr[FF_W-1:0] == ff_rd[FF_W-1:0]);

  // a full FIFO drops the new record
  assign push = cmp_vld & ~ff_full;
  assign pop  = trace_vld & trace_rdy;

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      ff_wr <= '0;
      ff_rd <= '0;
    end else begin
      if (push) ff_wr <= ff_wr + 1'b1;
      if (pop) ff_rd <= ff_rd + 1'b1;
    end
  end

  always_ff @(posedge tcb) begin
    if (push) fifo[ff_wr[FF_W-1:0]] <= rec_in;
  end

  // head entry stays put until popped
  assign trace_vld = ~ff_empty;
  assign trace_rec = fifo[ff_rd[FF_W-1:0]];

  //////////////////////////////
  // trace statistics
  //////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      trace_stats <= '0;
    end else begin
      // errors count even when the record is dropped
      if (cmp_vld && cmp_rsp.err) trace_stats.err_cnt <= trace_stats.err_cnt + 32'd1;
      if (cmp_vld && ff_full) trace_stats.drop_cnt <= trace_stats.drop_cnt + 32'd1;
    end
  end

endmodule

// ==== tcb_mon_top.sv ====
//////////////////////////////
// tcb monitor top
// request tracker, timing counter
// and trace merger side by side
//////////////////////////////

`timescale 1ns/1ps

module tcb_mon_top #(
  parameter int DLY         = 2,
  parameter int TRACE_DEPTH = 8
) (
  input  logic                    tcb,
  input  logic                    rst_n,
  // observed bus
  input  logic                    bus_vld,
  input  logic                    bus_rdy,
  input  tcb_pkg::bus_req_t       bus_req,
  input  tcb_pkg::bus_rsp_t       bus_rsp,
  // trace stream
  input  logic                    trace_rdy,
  output logic                    trace_vld,
  output trace_pkg::trace_rec_t   trace_rec,
  // statistics
  output tcb_pkg::bus_stats_t     bus_stats,
  output trace_pkg::trace_stats_t trace_stats
);

  // tracker to merger
  logic              cmp_vld;
  tcb_pkg::bus_req_t cmp_req;
  tcb_pkg::bus_rsp_t cmp_rsp;
  // counter to merger
  logic              snap_vld;
  trace_pkg::tmg_t   snap_tmg;

  tcb_req_tracker #(
    .DLY (DLY)
  ) i_tcb_req_tracker (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .bus_vld (bus_vld),
    .bus_rdy (bus_rdy),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .cmp_vld (cmp_vld),
    .cmp_req (cmp_req),
    .cmp_rsp (cmp_rsp)
  );

  tcb_tmg_counter i_tcb_tmg_counter (
    .tcb       (tcb),
    .rst_n     (rst_n),
    .bus_vld   (bus_vld),
    .bus_rdy   (bus_rdy),
    .bus_req   (bus_req),
    .snap_vld  (snap_vld),
    .snap_tmg  (snap_tmg),
    .bus_stats (bus_stats)
  );

  // in-order merge and trace FIFO
  tcb_trace_merge #(
    .DLY         (DLY),
    .TRACE_DEPTH (TRACE_DEPTH)
  ) i_tcb_trace_merge (
    .tcb         (tcb),
    .rst_n       (rst_n),
    .cmp_vld     (cmp_vld),
    .cmp_req     (cmp_req),
    .cmp_rsp     (cmp_rsp),
    .snap_vld    (snap_vld),
    .snap_tmg    (snap_tmg),
    .trace_rdy   (trace_rdy),
    .trace_vld   (trace_vld),
    .trace_rec   (trace_rec),
    .trace_stats (trace_stats)
  );

endmodule

// ==== tcb_mon_properties.sv ====
//////////////////////////////
// tcb monitor properties
// trace stream and statistics checks
//////////////////////////////

`timescale 1ns/1ps

module tcb_mon_properties (
  input logic                  tcb,
  input logic                  rst_n,
  input logic                  trace_vld,
  input logic                  trace_rdy,
  input trace_pkg::trace_rec_t trace_rec,
  input tcb_pkg::bus_stats_t   bus_stats
);

  // failed assertions so far
  int fail_cnt = 0;

  // stalled record stays offered and unchanged
  rec_stable: assert property (
    @(posedge tcb) disable iff (!rst_n)
    trace_vld && !trace_rdy |=> trace_vld && $stable(trace_rec)
  ) else begin
    $error("trace record changed while the stream was stalled");
    fail_cnt++;
  end

  // FIFO empty while in reset
  vld_in_reset: assert property (
    @(posedge tcb) !rst_n |=> !trace_vld
  ) else begin
    $error("trace_vld high during reset");
    fail_cnt++;
  end

  // transfer count only grows
  xfer_monotonic: assert property (
    @(posedge tcb) disable iff (!rst_n)
    bus_stats.xfer_cnt >= $past(bus_stats.xfer_cnt)
  ) else begin
    $error("xfer_cnt decreased");
    fail_cnt++;
  end

endmodule

bind tcb_mon_top tcb_mon_properties i_tcb_mon_properties (
  .tcb       (tcb),
  .rst_n     (rst_n),
  .trace_vld (trace_vld),
  .trace_rdy (trace_rdy),
  .trace_rec (trace_rec),
  .bus_stats (bus_stats)
);

// ==== tcb_mon_tb.sv ====
//////////////////////////////
// tcb monitor testbench
// plays bus manager and responder from a data file,
// checks trace records and statistics
//////////////////////////////

`timescale 1ns/1ps

module tcb_mon_tb;

  localparam int DLY         = 2;
  localparam int TRACE_DEPTH = 8;
  localparam int CLK_PERIOD  = 100;

  logic                    tcb;
  logic                    rst_n;
  logic                    bus_vld;
  logic                    bus_rdy;
  tcb_pkg::bus_req_t       bus_req;
  tcb_pkg::bus_rsp_t       bus_rsp;
  logic                    trace_rdy;
  logic                    trace_vld;
  trace_pkg::trace_rec_t   trace_rec;
  tcb_pkg::bus_stats_t     bus_stats;
  trace_pkg::trace_stats_t trace_stats;

  integer seed = 32'h30b1ab75;
  // per-line file values
  int                    idl_q[$];
  int                    bpr_q[$];
  int                    mode_q[$];
  tcb_pkg::bus_rsp_t     rsp_q[$];
  tcb_pkg::bus_req_t     req_q[$];
  trace_pkg::trace_rec_t rec_q[$];
  int max_idl, max_bpr, n_wr, n_err, bpr_total;
  // responses in flight, due cycle and line index
  int due_q[$];
  int idx_q[$];
  // model of the trace FIFO contents
  trace_pkg::trace_rec_t exp_fifo[$];
  trace_pkg::trace_rec_t cmp_rec;
  bit     cmp_now;
  int     cyc, cur_mode, idle_tally, exp_drop;
  longint limit_ns;

  tcb_mon_top #(
    .DLY         (DLY),
    .TRACE_DEPTH (TRACE_DEPTH)
  ) i_tcb_mon_top (
    .tcb         (tcb),
    .rst_n       (rst_n),
    .bus_vld     (bus_vld),
    .bus_rdy     (bus_rdy),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .trace_rdy   (trace_rdy),
    .trace_vld   (trace_vld),
    .trace_rec   (trace_rec),
    .bus_stats   (bus_stats),
    .trace_stats (trace_stats)
  );

  initial tcb = 1'b0;
  always #(CLK_PERIOD / 2) tcb = ~tcb;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_rec(input trace_pkg::trace_rec_t got, input trace_pkg::trace_rec_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %0t: trace record %h, expected %h", $time, got, exp));
  endtask

  task automatic check_bus_stats(input tcb_pkg::bus_stats_t got, input tcb_pkg::bus_stats_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %0t: bus stats %h, expected %h", $time, got, exp));
  endtask

  task automatic check_trace_stats(input trace_pkg::trace_stats_t got,
                                   input trace_pkg::trace_stats_t exp);
    if (got !== exp) abort_run($sformatf("FAIL %0t: trace stats %h, expected %h", $time, got, exp));
  endtask

  // timing fields stop at 255
  function automatic logic [7:0] saturate(input int n);
    return (n > 255) ? 8'd255 : n[7:0];
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic load_lines();
    int                fd;
    int                f_idl, f_bpr, f_op, f_err, f_mode;
    logic [31:0]       f_adr, f_ben, f_wdt, f_rdt;
    logic [31:0]       line_idx;
    string             line;
    tcb_pkg::bus_req_t req;
    tcb_pkg::bus_rsp_t rsp;
    trace_pkg::trace_rec_t rec;
    fd = $fopen("tcb_mon_input.dat", "r");
    if (fd == 0) abort_run("could not open tcb_mon_input.dat for reading");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // comment and blank lines do not parse
      if ($sscanf(line, "%d %d %d %h %h %h %h %d %d", f_idl, f_bpr, f_op, f_adr, f_ben,
                  f_wdt, f_rdt, f_err, f_mode) == 9) begin
        line_idx = idl_q.size();
        req.op  = tcb_pkg::bus_op_t'(f_op[0]);
        req.adr = f_adr[15:0];
        req.ben = f_ben[3:0];
        req.wdt = f_wdt;
        // lock and repeat vary with the line number
        req.lck = line_idx[0];
        req.rpt = line_idx[1];
        rsp.rdt = f_rdt;
        rsp.err = f_err[0];
        rec.req = req;
        rec.rsp = rsp;
        rec.tmg.idl = saturate(f_idl);
        rec.tmg.bpr = saturate(f_bpr);
        // reads without any byte enable
        rec.no_ben = (f_op == 0) && (f_ben[3:0] == 4'h0);
        idl_q.push_back(f_idl);
        bpr_q.push_back(f_bpr);
        mode_q.push_back(f_mode);
        req_q.push_back(req);
        rsp_q.push_back(rsp);
        rec_q.push_back(rec);
        if (f_idl > max_idl) max_idl = f_idl;
        if (f_bpr > max_bpr) max_bpr = f_bpr;
        n_wr += f_op;
        n_err += f_err;
        bpr_total += f_bpr;
      end
    end
    $fclose(fd);
  endtask

  // one clock, inputs change 10 ns after the edge
  task automatic next_cycle();
    integer rnd;
    if (rst_n && !bus_vld) idle_tally++;
    @(posedge tcb);
    cyc++;
    #10;
    cmp_now = 1'b0;
    bus_rsp = '0;
    if (due_q.size() != 0 && due_q[0] == cyc) begin
      void'(due_q.pop_front());
      cmp_rec = rec_q[idx_q[0]];
      bus_rsp = rsp_q[idx_q.pop_front()];
      cmp_now = 1'b1;
    end
    case (cur_mode)
      0: trace_rdy = 1'b1;
      1: begin
        rnd = $random(seed);
        trace_rdy = rnd[0];
      end
      default: trace_rdy = 1'b0;
    endcase
  endtask

  // idle, then backpressure, then the transfer
  task automatic play_line(input int i);
    repeat (idl_q[i]) begin
      bus_vld = 1'b0;
      bus_rdy = 1'b0;
      bus_req = '0;
      next_cycle();
    end
    bus_req = req_q[i];
    repeat (bpr_q[i]) begin
      bus_vld = 1'b1;
      bus_rdy = 1'b0;
      next_cycle();
    end
    bus_vld = 1'b1;
    bus_rdy = 1'b1;
    // response goes out DLY-1 edges after the transfer edge
    due_q.push_back(cyc + DLY);
    idx_q.push_back(i);
    cur_mode = mode_q[i];
    next_cycle();
  endtask

  //////////////////////////////
  // trace stream checker
  //////////////////////////////

  // full is judged before this edge's pop
  always @(negedge tcb) begin
    if (i_tcb_mon_top.i_tcb_mon_properties.fail_cnt != 0)
      abort_run("a bound trace property failed, see the assertion error above");
    if (rst_n) begin
      if (trace_vld !== (exp_fifo.size() != 0))
        abort_run($sformatf("FAIL %0t: trace_vld %b with %0d records expected", $time,
                            trace_vld, exp_fifo.size()));
      if (cmp_now && exp_fifo.size() == TRACE_DEPTH) exp_drop++;
      else if (cmp_now) exp_fifo.push_back(cmp_rec);
      if (trace_vld && trace_rdy) check_rec(trace_rec, exp_fifo.pop_front());
    end
  end

  initial begin : watchdog
    wait (limit_ns > 0);
    #(limit_ns);
    abort_run("watchdog expired: the run did not complete, trace stream or bus stuck");
  end

  initial begin : run_tests
    tcb_pkg::bus_stats_t     exp_bus;
    trace_pkg::trace_stats_t exp_trc;
    rst_n     = 1'b0;
    bus_vld   = 1'b0;
    bus_rdy   = 1'b0;
    bus_req   = '0;
    bus_rsp   = '0;
    trace_rdy = 1'b1;
    load_lines();
    limit_ns = (longint'(idl_q.size()) * (max_idl + max_bpr + DLY + 20) + 16) * CLK_PERIOD;
    repeat (16) next_cycle();
    rst_n = 1'b1;
    foreach (idl_q[i]) play_line(i);
    // bus quiet, sink drains the rest
    bus_vld  = 1'b0;
    bus_rdy  = 1'b0;
    bus_req  = '0;
    cur_mode = 0;
    while (due_q.size() != 0 || cmp_now || exp_fifo.size() != 0) next_cycle();
    // no extra record left behind
    if (trace_vld !== 1'b0)
      abort_run($sformatf("FAIL %0t: trace_vld still high after the last record", $time));
    exp_bus.xfer_cnt = idl_q.size();
    exp_bus.wr_cnt   = n_wr;
    exp_bus.idle_sum = idle_tally;
    exp_bus.bpr_sum  = bpr_total;
    check_bus_stats(bus_stats, exp_bus);
    exp_trc.err_cnt  = n_err;
    exp_trc.drop_cnt = exp_drop;
    check_trace_stats(trace_stats, exp_trc);
    if (i_tcb_mon_top.i_tcb_mon_properties.fail_cnt != 0) begin
      abort_run("a bound trace property failed, see the assertion error above");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== src.f ====
tcb_pkg.sv
trace_pkg.sv
tcb_req_tracker.sv
tcb_tmg_counter.sv
tcb_trace_merge.sv
tcb_mon_top.sv
tcb_mon_properties.sv
tcb_mon_tb.sv

// ==== tcb_mon_input.dat ====
# idle bpr op adr ben wdt rdt err mode   (op 0 read 1 write, adr ben wdt rdt in hex)
# mode 0 trace_rdy high, 1 random, 2 low; a line's mode holds from its transfer on
0   0   0 0010 f 00000000 a5a50001 0 0
0   0   1 0014 f 12345678 00000000 0 0
300 0   0 0020 3 00000000 0badf00d 0 0
2   270 1 0024 c cafe0000 00000000 0 0
0   0   0 0028 f 00000000 11110002 0 0
0   0   1 002c 0 deadbeef 00000000 0 0
0   0   0 0030 0 00000000 22220003 1 0
1   3   1 0034 f 55aa55aa 00000000 1 0
2   0   0 0100 f 00000000 30000000 0 2
0   0   1 0104 f 30000001 00000000 0 2
0   0   0 0108 f 00000000 30000002 0 2
0   0   1 010c 1 30000003 00000000 0 2
0   0   0 0110 f 00000000 30000004 0 2
0   0   1 0114 f 30000005 00000000 0 2
0   0   0 0118 8 00000000 30000006 0 2
0   0   1 011c f 30000007 00000000 0 2
0   0   0 0120 f 00000000 30000008 0 2
0   0   1 0124 f 30000009 00000000 0 2
0   0   0 0128 f 00000000 3000000a 0 2
0   0   0 012c f 00000000 3000000b 1 2
3   0   0 0200 f 00000000 40000000 0 0
1   0   1 0204 f 40000001 00000000 0 1
0   2   0 0208 6 00000000 40000002 0 1
0   0   1 020c f 40000003 00000000 1 1
